// ==== rtl/xcom_pkg.sv ====
// xcom link definitions
package xcom_pkg;

  ////////////////////
  // link constants
  ////////////////////

  // receive channels and the width of a channel index
  localparam int NCH   = 2;
  localparam int NCH_W = (NCH > 1) ? $clog2(NCH) : 1;

  localparam int XCOM_WORD_W = 32;
  localparam int XCOM_HDR_W  = 8;
  // start bit, header and the longest data field
  localparam int XCOM_FRAME_W = 1 + XCOM_HDR_W + XCOM_WORD_W;

  ////////////////////
  // basic types
  ////////////////////

  typedef logic [XCOM_WORD_W-1:0] xcom_word_t;
  typedef logic [3:0]             xcom_id_t;
  // half period of the link clock is 2*(tick+1) cycles
  typedef logic [2:0]             cfg_tick_t;

  // data length code, header bits 6:5
  typedef enum logic [1:0] {
    LEN_NONE = 2'b00,
    LEN_8    = 2'b01,
    LEN_16   = 2'b10,
    LEN_32   = 2'b11
  } xcom_len_e;

  // function code, header bits 4:0
  typedef enum logic [4:0] {
    FN_WRITE_WORD  = 5'h01,
    FN_PROC_START  = 5'h02,
    FN_PROC_STOP   = 5'h03,
    FN_TIME_RST    = 5'h04,
    FN_TIME_UPDATE = 5'h05
  } xcom_func_e;

  // core opcodes, network ones share the function code value
  typedef enum logic [4:0] {
    OP_WRITE_WORD  = 5'h01,
    OP_PROC_START  = 5'h02,
    OP_PROC_STOP   = 5'h03,
    OP_TIME_RST    = 5'h04,
    OP_TIME_UPDATE = 5'h05,
    OP_SET_ID      = 5'h10
  } xcom_op_e;

  // bit 7 goes out as zero
  typedef struct packed {
    logic       rsvd;
    xcom_len_e  len;
    xcom_func_e func;
  } xcom_header_t;

  // number of data bits that follow the header
  function automatic int unsigned len_bits(input xcom_len_e len);
    case (len)
      LEN_8:   return 8;
      LEN_16:  return 16;
      LEN_32:  return 32;
      default: return 0;
    endcase
  endfunction

endpackage

// ==== rtl/xcom_tx_if.sv ====
// xcom transmit request interface
`timescale 1ns/1ps

interface xcom_tx_if
  import xcom_pkg::*;
();

  // one cycle request, only while busy is low
  logic         req;
  // header and word, held stable by the decoder
  xcom_header_t header;
  xcom_word_t   data;
  // high from the cycle after req until the last bit is out
  logic         busy;

  // command decoder side
  modport cmd (
    output req,
    output header,
    output data,
    input  busy
  );

  // serializer side
  modport tx (
    input  req,
    input  header,
    input  data,
    output busy
  );

endinterface

// ==== rtl/xcom_cmd.sv ====
// xcom command decoder
`timescale 1ns/1ps

module xcom_cmd
  import xcom_pkg::*;
(
  input  logic       i_ps_clk,
  input  logic       i_ps_rstn,
  input  logic       i_core_en,
  input  xcom_op_e   i_core_op,
  input  xcom_word_t i_core_data,
  output xcom_id_t   o_xcom_id,
  output logic       o_core_ready,
  xcom_tx_if.cmd     tx
);

  logic         pending;
  logic         accept;
  logic         is_net;
  xcom_func_e   net_func;
  xcom_id_t     id_q;
  xcom_header_t hdr_q;
  xcom_word_t   data_q;

  // fixed data length for each function
  function automatic xcom_len_e func_len(input xcom_func_e fn);
    case (fn)
      FN_WRITE_WORD,
      FN_TIME_UPDATE: return LEN_32;
      default:        return LEN_NONE;
    endcase
  endfunction

  ////////////////////
  // decode
  ////////////////////

  always_comb begin
    case (i_core_op)
      OP_WRITE_WORD,
      OP_PROC_START,
      OP_PROC_STOP,
      OP_TIME_RST,
      OP_TIME_UPDATE: is_net = 1'b1;
      default:        is_net = 1'b0;
    endcase
  end

  // network opcode maps straight onto its function
  assign net_func = xcom_func_e'(i_core_op);

  // strobes while not ready are dropped
  assign accept       = i_core_en && o_core_ready;
  assign o_core_ready = !pending && !tx.busy;

  ////////////////////
  // control state
  ////////////////////

  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      pending <= 1'b0;
      id_q    <= '0;
    end else begin
      // request leaves on the cycle after the strobe
      if (tx.req) begin
        pending <= 1'b0;
      end else if (accept && is_net) begin
        pending <= 1'b1;
      end
      // local command, ready stays up
      if (accept && i_core_op == OP_SET_ID) begin
        id_q <= i_core_data[3:0];
      end
    end
  end

  // request payload, held until the next accepted command
  always_ff @(posedge i_ps_clk) begin
    if (accept && is_net) begin
      hdr_q.rsvd <= 1'b0;
      hdr_q.len  <= func_len(net_func);
      hdr_q.func <= net_func;
      data_q     <= i_core_data;
    end
  end

  assign tx.req    = pending && !tx.busy;
  assign tx.header = hdr_q;
  assign tx.data   = data_q;
  assign o_xcom_id = id_q;

endmodule

// ==== rtl/xcom_tx.sv ====
// xcom frame serializer
`timescale 1ns/1ps

module xcom_tx
  import xcom_pkg::*;
(
  input  logic      i_ps_clk,
  input  logic      i_ps_rstn,
  input  cfg_tick_t i_cfg_tick,
  xcom_tx_if.tx     tx,
  output logic      o_xcom_clk,
  output logic      o_xcom_data
);

  logic                    busy;
  logic                    clk_q;
  logic                    dat_q;
  logic [3:0]              half_cnt;
  logic                    half_end;
  logic                    bit_end;
  logic [5:0]              bits_left;
  logic [5:0]              frame_bits;
  logic [XCOM_FRAME_W-1:0] frame;
  logic [XCOM_FRAME_W-1:0] shreg;

  ////////////////////
  // frame build
  ////////////////////

  // start bit, header, then data pushed up against the header, msb first
  assign frame = {1'b1,
                  tx.header,
                  tx.data << (XCOM_WORD_W - len_bits(tx.header.len))};

  // bits that follow the start bit
  assign frame_bits = 6'(XCOM_HDR_W + len_bits(tx.header.len));

  ////////////////////
  // link clock
  ////////////////////

  // last cycle of a half period of 2*(tick+1) cycles
  assign half_end = (half_cnt == {i_cfg_tick, 1'b1});
  // falling edge of the link clock closes a bit period
  assign bit_end  = half_end && clk_q;

  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      busy      <= 1'b0;
      clk_q     <= 1'b0;
      dat_q     <= 1'b0;
      half_cnt  <= '0;
      bits_left <= '0;
    end else if (!busy) begin
      half_cnt <= '0;
      clk_q    <= 1'b0;
      if (tx.req) begin
        busy      <= 1'b1;
        // start bit goes out with the clock low
        dat_q     <= frame[XCOM_FRAME_W-1];
        bits_left <= frame_bits;
      end
    end else if (half_end) begin
      half_cnt <= '0;
      clk_q    <= ~clk_q;
      if (bit_end) begin
        if (bits_left == '0) begin
          // frame done, both lines back to idle low
          busy  <= 1'b0;
          dat_q <= 1'b0;
        end else begin
          // next bit while the clock is low
          dat_q     <= shreg[XCOM_FRAME_W-1];
          bits_left <= bits_left - 6'd1;
        end
      end
    end else begin
      half_cnt <= half_cnt + 4'd1;
    end
  end

  ////////////////////
  // shift register
  ////////////////////

  // holds the bits not yet on the line, msb next
  always_ff @(posedge i_ps_clk) begin
    if (!busy && tx.req) begin
      shreg <= frame << 1;
    end else if (busy && bit_end) begin
      shreg <= shreg << 1;
    end
  end

  assign tx.busy     = busy;
  assign o_xcom_clk  = clk_q;
  assign o_xcom_data = dat_q;

endmodule

// ==== rtl/xcom_rx.sv ====
// xcom frame deserializer
`timescale 1ns/1ps

module xcom_rx
  import xcom_pkg::*;
(
  input  logic           i_ps_clk,
  input  logic           i_ps_rstn,
  input  logic [NCH-1:0] i_xcom_clk,
  input  logic [NCH-1:0] i_xcom_data,
  output logic           o_frame_done,
  output xcom_header_t   o_header,
  output xcom_word_t     o_data
);

  typedef enum logic [1:0] {RX_IDLE, RX_HDR, RX_DATA} rx_state_e;

  logic [NCH-1:0]   clk_meta;
  logic [NCH-1:0]   clk_sync;
  logic [NCH-1:0]   clk_prev;
  logic [NCH-1:0]   dat_meta;
  logic [NCH-1:0]   dat_sync;
  logic [NCH-1:0]   rise;
  rx_state_e        state;
  logic [NCH_W-1:0] ch_q;
  logic [NCH_W-1:0] start_ch;
  logic             start_hit;
  logic             sel_rise;
  logic             sel_bit;
  logic             last_hdr;
  logic             last_dat;
  logic [5:0]       bit_cnt;
  xcom_header_t     hdr_sr;
  xcom_header_t     hdr_next;
  xcom_word_t       data_sr;
  xcom_word_t       data_next;

  ////////////////////
  // sync and edges
  ////////////////////

  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      clk_meta <= '0;
      clk_sync <= '0;
      clk_prev <= '0;
      dat_meta <= '0;
      dat_sync <= '0;
    end else begin
      clk_meta <= i_xcom_clk;
      clk_sync <= clk_meta;
      clk_prev <= clk_sync;
      dat_meta <= i_xcom_data;
      dat_sync <= dat_meta;
    end
  end

  assign rise = clk_sync & ~clk_prev;

  // start bit on any channel, lowest index wins
  always_comb begin
    start_hit = 1'b0;
    start_ch  = '0;
    for (int i = NCH - 1; i >= 0; i--) begin
      if (rise[i] && dat_sync[i]) begin
        start_hit = 1'b1;
        start_ch  = NCH_W'(i);
      end
    end
  end

  // locked channel
  assign sel_rise  = rise[ch_q];
  assign sel_bit   = dat_sync[ch_q];
  assign hdr_next  = xcom_header_t'({hdr_sr[XCOM_HDR_W-2:0], sel_bit});
  assign data_next = {data_sr[XCOM_WORD_W-2:0], sel_bit};
  assign last_hdr  = (state == RX_HDR) && sel_rise && (bit_cnt == '0);
  assign last_dat  = (state == RX_DATA) && sel_rise && (bit_cnt == '0);

  ////////////////////
  // frame FSM
  ////////////////////

  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      state        <= RX_IDLE;
      ch_q         <= '0;
      bit_cnt      <= '0;
      o_frame_done <= 1'b0;
    end else begin
      o_frame_done <= 1'b0;
      case (state)
        RX_IDLE: if (start_hit) begin
          ch_q    <= start_ch;
          bit_cnt <= 6'(XCOM_HDR_W - 1);
          state   <= RX_HDR;
        end
        RX_HDR: if (sel_rise) begin
          if (bit_cnt != '0) begin
            bit_cnt <= bit_cnt - 6'd1;
          end else if (len_bits(hdr_next.len) == 0) begin
            // header only frame
            o_frame_done <= 1'b1;
            state        <= RX_IDLE;
          end else begin
            bit_cnt <= 6'(len_bits(hdr_next.len) - 1);
            state   <= RX_DATA;
          end
        end
        RX_DATA: if (sel_rise) begin
          if (bit_cnt != '0) begin
            bit_cnt <= bit_cnt - 6'd1;
          end else begin
            o_frame_done <= 1'b1;
            state        <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // shift registers and frame result
  always_ff @(posedge i_ps_clk) begin
    // cleared while idle so short data lands right aligned
    if (state == RX_IDLE) begin
      data_sr <= '0;
    end else if (state == RX_DATA && sel_rise) begin
      data_sr <= data_next;
    end
    if (state == RX_HDR && sel_rise) begin
      hdr_sr <= hdr_next;
    end
    if (last_hdr) begin
      o_header <= hdr_next;
      o_data   <= '0;
    end
    if (last_dat) begin
      o_header <= hdr_sr;
      o_data   <= data_next;
    end
  end

endmodule

// ==== rtl/xcom_exec.sv ====
// xcom received frame executor
`timescale 1ns/1ps

module xcom_exec
  import xcom_pkg::*;
(
  input  logic         i_ps_clk,
  input  logic         i_ps_rstn,
  input  logic         i_frame_done,
  input  xcom_header_t i_header,
  input  xcom_word_t   i_data,
  output logic         o_proc_start,
  output logic         o_proc_stop,
  output logic         o_time_rst,
  output logic         o_time_update,
  output xcom_word_t   o_time_update_data,
  output logic         o_core_valid,
  output xcom_word_t   o_core_data1,
  output xcom_word_t   o_core_data2
);

  logic hit_start;
  logic hit_stop;
  logic hit_trst;
  logic hit_tupd;
  logic hit_word;

  ////////////////////
  // function decode
  ////////////////////

  // unknown codes match nothing
  assign hit_start = i_frame_done && (i_header.func == FN_PROC_START);
  assign hit_stop  = i_frame_done && (i_header.func == FN_PROC_STOP);
  assign hit_trst  = i_frame_done && (i_header.func == FN_TIME_RST);
  assign hit_tupd  = i_frame_done && (i_header.func == FN_TIME_UPDATE);
  assign hit_word  = i_frame_done && (i_header.func == FN_WRITE_WORD);

  // one cycle pulses, one per frame
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      o_proc_start  <= 1'b0;
      o_proc_stop   <= 1'b0;
      o_time_rst    <= 1'b0;
      o_time_update <= 1'b0;
      o_core_valid  <= 1'b0;
    end else begin
      o_proc_start  <= hit_start;
      o_proc_stop   <= hit_stop;
      o_time_rst    <= hit_trst;
      o_time_update <= hit_tupd;
      o_core_valid  <= hit_word;
    end
  end

  // payload held until the next frame of the same kind
  always_ff @(posedge i_ps_clk) begin
    if (hit_tupd) begin
      o_time_update_data <= i_data;
    end
    if (hit_word) begin
      // header zero extended into the first report word
      o_core_data1 <= {{(XCOM_WORD_W - $bits(xcom_header_t)){1'b0}}, i_header};
      o_core_data2 <= i_data;
    end
  end

endmodule

// ==== rtl/xcom_top.sv ====
// xcom link top level
`timescale 1ns/1ps

module xcom_top
  import xcom_pkg::*;
(
  input  logic           i_ps_clk,
  input  logic           i_ps_rstn,
  // core command port
  input  logic           i_core_en,
  input  xcom_op_e       i_core_op,
  input  xcom_word_t     i_core_data,
  output logic           o_core_ready,
  output logic           o_core_valid,
  output xcom_word_t     o_core_data1,
  output xcom_word_t     o_core_data2,
  // control outputs
  output logic           o_proc_start,
  output logic           o_proc_stop,
  output logic           o_time_rst,
  output logic           o_time_update,
  output xcom_word_t     o_time_update_data,
  output xcom_id_t       o_xcom_id,
  // link
  input  cfg_tick_t      i_cfg_tick,
  input  logic [NCH-1:0] i_xcom_clk,
  input  logic [NCH-1:0] i_xcom_data,
  output logic           o_xcom_clk,
  output logic           o_xcom_data
);

  logic         frame_done;
  xcom_header_t rx_header;
  xcom_word_t   rx_data;

  ////////////////////
  // transmit path
  ////////////////////

  xcom_tx_if tx_if ();

  xcom_cmd xcom_cmd_i (
    .i_ps_clk     (i_ps_clk),
    .i_ps_rstn    (i_ps_rstn),
    .i_core_en    (i_core_en),
    .i_core_op    (i_core_op),
    .i_core_data  (i_core_data),
    .o_xcom_id    (o_xcom_id),
    .o_core_ready (o_core_ready),
    .tx           (tx_if.cmd)
  );

  xcom_tx xcom_tx_i (
    .i_ps_clk    (i_ps_clk),
    .i_ps_rstn   (i_ps_rstn),
    .i_cfg_tick  (i_cfg_tick),
    .tx          (tx_if.tx),
    .o_xcom_clk  (o_xcom_clk),
    .o_xcom_data (o_xcom_data)
  );

  ////////////////////
  // receive path
  ////////////////////

  xcom_rx xcom_rx_i (
    .i_ps_clk     (i_ps_clk),
    .i_ps_rstn    (i_ps_rstn),
    .i_xcom_clk   (i_xcom_clk),
    .i_xcom_data  (i_xcom_data),
    .o_frame_done (frame_done),
    .o_header     (rx_header),
    .o_data       (rx_data)
  );

  xcom_exec xcom_exec_i (
    .i_ps_clk           (i_ps_clk),
    .i_ps_rstn          (i_ps_rstn),
    .i_frame_done       (frame_done),
    .i_header           (rx_header),
    .i_data             (rx_data),
    .o_proc_start       (o_proc_start),
    .o_proc_stop        (o_proc_stop),
    .o_time_rst         (o_time_rst),
    .o_time_update      (o_time_update),
    .o_time_update_data (o_time_update_data),
    .o_core_valid       (o_core_valid),
    .o_core_data1       (o_core_data1),
    .o_core_data2       (o_core_data2)
  );

endmodule

// ==== dv/xcom_tb_checks.svh ====
// xcom testbench checks
`ifndef XCOM_TB_CHECKS_SVH
`define XCOM_TB_CHECKS_SVH

// running totals for the closing line
int n_checks     = 0;
int value_errors = 0;
int other_errors = 0;

// single bit results, flags and pulse levels
task automatic check_flag(input string name, input logic got, input logic exp);
  n_checks++;
  if (got !== exp) begin
    value_errors++;
    $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

// data words, header reports and pulse counts
task automatic check_word(input string name, input xcom_word_t got, input xcom_word_t exp);
  n_checks++;
  if (got !== exp) begin
    value_errors++;
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

// board identifier
task automatic check_id(input string name, input xcom_id_t got, input xcom_id_t exp);
  n_checks++;
  if (got !== exp) begin
    value_errors++;
    $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic note_timeout(input string what);
  other_errors++;
  $display("timeout at %0t while waiting for %s", $time, what);
endtask

task automatic note_failure(input string what);
  other_errors++;
  $display("failure at %0t: %s", $time, what);
endtask

`endif

// ==== dv/xcom_tb.sv ====
// xcom link testbench
`timescale 1ns/1ps

module xcom_tb
  import xcom_pkg::*;
();

  logic           i_ps_clk;
  logic           i_ps_rstn;
  logic           i_core_en;
  xcom_op_e       i_core_op;
  xcom_word_t     i_core_data;
  cfg_tick_t      i_cfg_tick;
  logic [NCH-1:0] i_xcom_clk;
  logic [NCH-1:0] i_xcom_data;
  logic           o_core_ready;
  logic           o_core_valid;
  xcom_word_t     o_core_data1;
  xcom_word_t     o_core_data2;
  logic           o_proc_start;
  logic           o_proc_stop;
  logic           o_time_rst;
  logic           o_time_update;
  xcom_word_t     o_time_update_data;
  xcom_id_t       o_xcom_id;
  logic           o_xcom_clk;
  logic           o_xcom_data;

  // channel that carries the loopback
  int             loop_ch;
  // pulses seen per output since the last command
  int             cnt_start;
  int             cnt_stop;
  int             cnt_trst;
  int             cnt_tupd;
  int             cnt_valid;
  xcom_word_t     cap_data1;
  xcom_word_t     cap_data2;
  xcom_word_t     cap_tupd;

  `include "xcom_tb_checks.svh"

  ////////////////////
  // clock and DUT
  ////////////////////

  initial i_ps_clk = 1'b0;
  always #5 i_ps_clk = ~i_ps_clk;

  xcom_top xcom_top_i (
    .i_ps_clk           (i_ps_clk),
    .i_ps_rstn          (i_ps_rstn),
    .i_core_en          (i_core_en),
    .i_core_op          (i_core_op),
    .i_core_data        (i_core_data),
    .o_core_ready       (o_core_ready),
    .o_core_valid       (o_core_valid),
    .o_core_data1       (o_core_data1),
    .o_core_data2       (o_core_data2),
    .o_proc_start       (o_proc_start),
    .o_proc_stop        (o_proc_stop),
    .o_time_rst         (o_time_rst),
    .o_time_update      (o_time_update),
    .o_time_update_data (o_time_update_data),
    .o_xcom_id          (o_xcom_id),
    .i_cfg_tick         (i_cfg_tick),
    .i_xcom_clk         (i_xcom_clk),
    .i_xcom_data        (i_xcom_data),
    .o_xcom_clk         (o_xcom_clk),
    .o_xcom_data        (o_xcom_data)
  );

  // transmitter looped into one channel, the other held low
  always_comb begin
    for (int i = 0; i < NCH; i++) begin
      i_xcom_clk[i]  = (i == loop_ch) ? o_xcom_clk : 1'b0;
      i_xcom_data[i] = (i == loop_ch) ? o_xcom_data : 1'b0;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  // header as a zero extended word, full word length for data functions
  function automatic xcom_word_t exp_header(input xcom_op_e op);
    logic [1:0] len_code;
    if (op == OP_WRITE_WORD || op == OP_TIME_UPDATE) len_code = 2'b11;
    else len_code = 2'b00;
    return {24'h0, 1'b0, len_code, 5'(op)};
  endfunction

  task automatic clear_counts();
    cnt_start = 0;
    cnt_stop  = 0;
    cnt_trst  = 0;
    cnt_tupd  = 0;
    cnt_valid = 0;
  endtask

  // called once per cycle at the falling edge
  task automatic sample_pulses();
    if (o_proc_start) cnt_start++;
    if (o_proc_stop) cnt_stop++;
    if (o_time_rst) cnt_trst++;
    if (o_core_valid) begin
      cnt_valid++;
      cap_data1 = o_core_data1;
      cap_data2 = o_core_data2;
    end
    if (o_time_update) begin
      cnt_tupd++;
      cap_tupd = o_time_update_data;
    end
  endtask

  // one cycle strobe, returns on the next falling edge
  task automatic issue_cmd(input xcom_op_e op, input xcom_word_t data);
    i_core_en   = 1'b1;
    i_core_op   = op;
    i_core_data = data;
    @(negedge i_ps_clk);
    sample_pulses();
    i_core_en = 1'b0;
  endtask

  task automatic wait_ready();
    int cyc;
    cyc = 0;
    while (!o_core_ready && cyc < 4000) begin
      @(negedge i_ps_clk);
      cyc++;
    end
    if (!o_core_ready) note_timeout("o_core_ready before a new command");
  endtask

  task automatic check_reset();
    check_flag("o_core_ready", o_core_ready, 1'b1);
    check_id("o_xcom_id", o_xcom_id, 4'h0);
    check_flag("o_proc_start", o_proc_start, 1'b0);
    check_flag("o_proc_stop", o_proc_stop, 1'b0);
    check_flag("o_time_rst", o_time_rst, 1'b0);
    check_flag("o_time_update", o_time_update, 1'b0);
    check_flag("o_core_valid", o_core_valid, 1'b0);
    check_flag("o_xcom_clk", o_xcom_clk, 1'b0);
    check_flag("o_xcom_data", o_xcom_data, 1'b0);
  endtask

  task automatic run_set_id(input xcom_word_t data);
    issue_cmd(OP_SET_ID, data);
    // low nibble lands on the strobe edge
    check_id("o_xcom_id", o_xcom_id, data[3:0]);
    check_flag("o_core_ready", o_core_ready, 1'b1);
  endtask

  ////////////////////
  // network command
  ////////////////////

  task automatic run_network(input xcom_op_e op, input xcom_word_t data, input int tick,
                             input int kind);
    int bound;
    int min_cyc;
    int cyc;
    int ready_cyc;
    bit done;
    // longest frame plus a few cycles of slack
    bound = 4 * (tick + 1) * 41 + 10;
    // ready stays low for at least the serial time of this frame
    if (op == OP_WRITE_WORD || op == OP_TIME_UPDATE) min_cyc = 4 * (tick + 1) * 41;
    else min_cyc = 4 * (tick + 1) * 9;
    clear_counts();
    issue_cmd(op, data);
    check_flag("o_core_ready", o_core_ready, 1'b0);
    cyc = 1;
    if (kind == 2) begin
      // strobe while ready is low, must be dropped
      issue_cmd(op, ~data);
      cyc++;
    end
    ready_cyc = -1;
    done      = 1'b0;
    while (!done && cyc < bound + 40) begin
      @(negedge i_ps_clk);
      sample_pulses();
      cyc++;
      if (ready_cyc < 0 && o_core_ready) ready_cyc = cyc;
      if (ready_cyc >= 0 && (cnt_start + cnt_stop + cnt_trst + cnt_tupd + cnt_valid) > 0)
        done = 1'b1;
    end
    if (!done) begin
      note_timeout("a received frame and o_core_ready");
    end else if (ready_cyc > bound) begin
      note_failure($sformatf("o_core_ready came back after %0d cycles, limit %0d",
                             ready_cyc, bound));
    end else if (ready_cyc < min_cyc) begin
      note_failure($sformatf("o_core_ready came back after %0d cycles, frame needs %0d",
                             ready_cyc, min_cyc));
    end
    // quiet window, a second frame would show up here
    cyc = 0;
    while (cyc < bound) begin
      @(negedge i_ps_clk);
      sample_pulses();
      cyc++;
    end
    check_word("o_proc_start pulses", cnt_start, (op == OP_PROC_START) ? 1 : 0);
    check_word("o_proc_stop pulses", cnt_stop, (op == OP_PROC_STOP) ? 1 : 0);
    check_word("o_time_rst pulses", cnt_trst, (op == OP_TIME_RST) ? 1 : 0);
    check_word("o_time_update pulses", cnt_tupd, (op == OP_TIME_UPDATE) ? 1 : 0);
    check_word("o_core_valid pulses", cnt_valid, (op == OP_WRITE_WORD) ? 1 : 0);
    if (op == OP_WRITE_WORD && cnt_valid > 0) begin
      check_word("o_core_data1", cap_data1, exp_header(op));
      check_word("o_core_data2", cap_data2, data);
    end
    if (op == OP_TIME_UPDATE && cnt_tupd > 0) begin
      check_word("o_time_update_data", cap_tupd, data);
    end
    // link back to idle
    check_flag("o_xcom_clk", o_xcom_clk, 1'b0);
    check_flag("o_xcom_data", o_xcom_data, 1'b0);
    check_flag("o_core_ready", o_core_ready, 1'b1);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int               fd;
    int               n;
    int               lines;
    logic [8*256-1:0] skip_buf;
    logic [31:0]      op_val;
    logic [31:0]      data_val;
    int               tick_val;
    int               ch_val;
    int               kind_val;
    i_ps_rstn   = 1'b0;
    i_core_en   = 1'b0;
    i_core_op   = OP_WRITE_WORD;
    i_core_data = '0;
    i_cfg_tick  = '0;
    loop_ch     = 0;
    clear_counts();
    repeat (16) @(negedge i_ps_clk);
    i_ps_rstn = 1'b1;
    @(negedge i_ps_clk);
    check_reset();
    fd = $fopen("dv/xcom_stimulus.txt", "r");
    if (fd == 0) begin
      note_failure("could not open dv/xcom_stimulus.txt");
    end else begin
      lines = 0;
      while (!$feof(fd) && lines < 1000) begin
        lines++;
        n = $fscanf(fd, "%h %h %d %d %d", op_val, data_val, tick_val, ch_val, kind_val);
        if (n == 5) begin
          if (ch_val < 0 || ch_val >= NCH) begin
            note_failure("stimulus channel out of range");
            ch_val = 0;
          end
          // lines are idle here, safe to switch channel and speed
          loop_ch    = ch_val;
          i_cfg_tick = cfg_tick_t'(tick_val);
          wait_ready();
          if (kind_val == 0) run_set_id(data_val);
          else run_network(xcom_op_e'(op_val[4:0]), data_val, tick_val, kind_val);
        end else if (n >= 0) begin
          // comment line, or a broken one
          if (n > 0) note_failure("malformed stimulus line");
          n = $fgets(skip_buf, fd);
        end
      end
      $fclose(fd);
    end
    $display("checks %0d, value errors %0d, other errors %0d",
             n_checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== dv/xcom_stimulus.txt ====
# opcode(hex) data(hex) cfg_tick channel kind
# kind 0 local set-id, 1 network frame, 2 network frame plus a dropped strobe
10 0000000a 0 0 0
01 deadbeef 0 0 1
01 12345678 1 1 1
01 a5a5a5a5 3 0 1
01 0000ffff 7 1 1
05 cafef00d 0 1 1
05 00010203 2 0 1
02 00000000 0 0 1
03 00000000 1 1 1
04 00000000 2 0 1
10 00000003 0 1 0
01 87654321 1 0 2
02 00000000 0 1 2
10 fffffff5 0 0 0
05 13579bdf 0 0 2
04 00000000 3 1 1
03 00000000 0 0 2
01 80000001 2 1 1

// ==== files.f ====
+incdir+dv
rtl/xcom_pkg.sv
rtl/xcom_tx_if.sv
rtl/xcom_cmd.sv
rtl/xcom_tx.sv
rtl/xcom_rx.sv
rtl/xcom_exec.sv
rtl/xcom_top.sv
dv/xcom_tb.sv
